/* reflet_peripheral.f */
source/reflet_pkg.sv
source/reflet_bus_if.sv
source/reflet_hardware_info.sv
source/reflet_exti.sv
source/reflet_gpio.sv
source/reflet_timer.sv
source/reflet_pwm.sv
source/reflet_peripheral.sv
tb/reflet_clock_gen.sv
tb/reflet_peripheral_asserts.sv
tb/reflet_peripheral_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module reflet_peripheral_tb -f reflet_peripheral.f

sim_out=$(./obj_dir/Vreflet_peripheral_tb 2>&1 || true)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

/* source/reflet_bus_if.sv */
/*
 * One decoded access from the system bus,
 * as seen by every peripheral in the window.
 */
`timescale 1ns/1ps

interface reflet_bus_if;
    import reflet_pkg::*;

    logic                   sel;
    logic [offset_bits-1:0] offset;
    logic [word_size-1:0]   wdata;
    logic                   write_en;

    modport host (output sel, offset, wdata, write_en);

    modport periph (input sel, offset, wdata, write_en);

endinterface

/* source/reflet_exti.sv */
/*
 * External interrupt controller:
 * mask register, pending register with write-one-to-clear,
 * masked interrupt lines to the cpu.
 */
`timescale 1ns/1ps

module reflet_exti (
    input  logic                             clk,
    input  logic                             reset,
    reflet_bus_if.periph                     bus,
    output logic [reflet_pkg::word_size-1:0] rdata,
    input  logic [reflet_pkg::irq_count-1:0] src_pulse,
    output logic [reflet_pkg::irq_count-1:0] cpu_int
);
    import reflet_pkg::*;

    logic                   hit;
    logic                   wr;
    logic [offset_bits-1:0] word;

    logic [irq_count-1:0] mask;
    logic [irq_count-1:0] pending;
    logic [irq_count-1:0] clear;

    assign hit  = bus.sel && bus.offset >= offset_bits'(exti_off)
                  && bus.offset < offset_bits'(exti_off + exti_size);
    assign wr   = hit && bus.write_en;
    assign word = bus.offset - offset_bits'(exti_off);

    assign clear = (wr && word == offset_bits'(1)) ? bus.wdata[irq_count-1:0] : '0;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mask    <= '0;
            pending <= '0;
        end
        else
        begin
            if (wr && word == offset_bits'(0))
                mask <= bus.wdata[irq_count-1:0];
            // a new pulse beats a clear on the same edge
            pending <= (pending & ~clear) | src_pulse;
        end
    end

    assign cpu_int = pending & mask;

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (word)
                offset_bits'(0): rdata = word_size'(mask);
                offset_bits'(1): rdata = word_size'(pending);
                default:         rdata = '0;
            endcase
        end
    end

endmodule

/* source/reflet_gpio.sv */
/*
 * General purpose I/O port:
 * two-flop input synchronizer, output register,
 * masked rising-edge interrupt pulse.
 */
`timescale 1ns/1ps

module reflet_gpio (
    input  logic                             clk,
    input  logic                             reset,
    reflet_bus_if.periph                     bus,
    output logic [reflet_pkg::word_size-1:0] rdata,
    input  logic [15:0]                      gpi,
    output logic [15:0]                      gpo,
    output logic                             interrupt
);
    import reflet_pkg::*;

    logic                   hit;
    logic                   wr;
    logic [offset_bits-1:0] word;

    logic [15:0] gpi_meta;
    logic [15:0] gpi_sync;
    logic [15:0] gpi_prev;
    logic [15:0] int_mask;

    assign hit  = bus.sel && bus.offset >= offset_bits'(gpio_off)
                  && bus.offset < offset_bits'(gpio_off + gpio_size);
    assign wr   = hit && bus.write_en;
    assign word = bus.offset - offset_bits'(gpio_off);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            gpi_meta  <= '0;
            gpi_sync  <= '0;
            gpi_prev  <= '0;
            gpo       <= '0;
            int_mask  <= '0;
            interrupt <= 1'b0;
        end
        else
        begin
            gpi_meta <= gpi;
            gpi_sync <= gpi_meta;
            gpi_prev <= gpi_sync;
            // rise seen on synchronized bits only
            interrupt <= |(gpi_sync & ~gpi_prev & int_mask);
            if (wr && word == offset_bits'(1))
                gpo <= bus.wdata;
            if (wr && word == offset_bits'(2))
                int_mask <= bus.wdata;
        end
    end

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (word)
                offset_bits'(0): rdata = gpi_sync;
                offset_bits'(1): rdata = gpo;
                offset_bits'(2): rdata = int_mask;
                default:         rdata = '0;
            endcase
        end
    end

endmodule

/* source/reflet_hardware_info.sv */
/*
 * Read-only build description:
 * word size, clock frequency halves and peripheral presence map.
 */
`timescale 1ns/1ps

module reflet_hardware_info (
    reflet_bus_if.periph                      bus,
    output logic [reflet_pkg::word_size-1:0] rdata
);
    import reflet_pkg::*;

    logic                   hit;
    logic [offset_bits-1:0] word;

    assign hit  = bus.sel && bus.offset < offset_bits'(hwi_off + hwi_size);
    assign word = bus.offset - offset_bits'(hwi_off);

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (word)
                offset_bits'(0): rdata = word_size[word_size-1:0];
                offset_bits'(1): rdata = clk_freq[15:0];
                offset_bits'(2): rdata = clk_freq[31:16];
                // hwi, exti, gpio, timer, pwm all present
                offset_bits'(3): rdata = {11'b0, 5'b11111};
                default:         rdata = '0;
            endcase
        end
    end

endmodule

/* source/reflet_peripheral.sv */
/*
 * Peripheral block top level:
 * address window decode and offset,
 * read data OR of all peripherals,
 * hardware info, exti, gpio, timer and pwm instances.
 */
`timescale 1ns/1ps

module reflet_peripheral (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             enable,
    input  logic [reflet_pkg::word_size-1:0] addr,
    input  logic [reflet_pkg::word_size-1:0] data_in,
    output logic [reflet_pkg::word_size-1:0] data_out,
    input  logic                             write_en,
    input  logic [15:0]                      gpi,
    output logic [15:0]                      gpo,
    output logic                             pwm,
    output logic [reflet_pkg::irq_count-1:0] ext_int
);
    import reflet_pkg::*;

    logic [word_size-1:0] addr_diff;

    logic [word_size-1:0] hwi_rdata;
    logic [word_size-1:0] exti_rdata;
    logic [word_size-1:0] gpio_rdata;
    logic [word_size-1:0] timer_rdata;
    logic [word_size-1:0] pwm_rdata;

    logic gpio_int;
    logic timer_int;
    logic pwm_wrap;
    logic [irq_count-1:0] irq_pulse;

    reflet_bus_if bus ();

    // window decode
    assign addr_diff = addr - base_addr;

    assign bus.sel      = enable && addr >= base_addr && addr < base_addr + total_size;
    assign bus.offset   = addr_diff[offset_bits-1:0];
    assign bus.wdata    = data_in;
    assign bus.write_en = write_en;

    // unselected peripherals return zero
    assign data_out = hwi_rdata | exti_rdata | gpio_rdata | timer_rdata | pwm_rdata;

    assign irq_pulse[irq_gpio]  = gpio_int;
    assign irq_pulse[irq_timer] = timer_int;
    assign irq_pulse[irq_pwm]   = pwm_wrap;

    reflet_hardware_info i_hwi (
        .bus   (bus),
        .rdata (hwi_rdata)
    );

    reflet_exti i_exti (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus),
        .rdata     (exti_rdata),
        .src_pulse (irq_pulse),
        .cpu_int   (ext_int)
    );

    reflet_gpio i_gpio (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus),
        .rdata     (gpio_rdata),
        .gpi       (gpi),
        .gpo       (gpo),
        .interrupt (gpio_int)
    );

    reflet_timer i_timer (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus),
        .rdata     (timer_rdata),
        .interrupt (timer_int)
    );

    reflet_pwm i_pwm (
        .clk   (clk),
        .reset (reset),
        .bus   (bus),
        .rdata (pwm_rdata),
        .out   (pwm),
        .wrap  (pwm_wrap)
    );

endmodule

/* source/reflet_pkg.sv */
/*
 * Shared definitions for the peripheral block:
 * bus word size, window base address,
 * per-peripheral region sizes and offsets,
 * reported clock frequency and the interrupt source enum.
 */

package reflet_pkg;

    localparam int word_size = 16;

    localparam logic [word_size-1:0] base_addr = 16'hFF00;

    // region sizes in words
    localparam int hwi_size   = 4;
    localparam int exti_size  = 2;
    localparam int gpio_size  = 3;
    localparam int timer_size = 3;
    localparam int pwm_size   = 2;

    // each region starts where the previous one ends
    localparam int hwi_off   = 0;
    localparam int exti_off  = hwi_off + hwi_size;
    localparam int gpio_off  = exti_off + exti_size;
    localparam int timer_off = gpio_off + gpio_size;
    localparam int pwm_off   = timer_off + timer_size;

    localparam int total_size  = pwm_off + pwm_size;
    localparam int offset_bits = $clog2(total_size);

    localparam logic [31:0] clk_freq = 32'd1000000;

    // bit positions in the interrupt vector
    typedef enum logic [1:0] {
        irq_gpio  = 2'd0,
        irq_timer = 2'd1,
        irq_pwm   = 2'd2
    } irq_src_e;

    localparam int irq_count = 3;

endpackage

/* source/reflet_pwm.sv */
/*
 * PWM generator:
 * period and duty registers, free-running counter,
 * output compare and end-of-cycle wrap pulse.
 */
`timescale 1ns/1ps

module reflet_pwm (
    input  logic                             clk,
    input  logic                             reset,
    reflet_bus_if.periph                     bus,
    output logic [reflet_pkg::word_size-1:0] rdata,
    output logic                             out,
    output logic                             wrap
);
    import reflet_pkg::*;

    logic                   hit;
    logic                   wr;
    logic [offset_bits-1:0] word;

    logic [word_size-1:0] period;
    logic [word_size-1:0] duty;
    logic [word_size-1:0] count;

    assign hit  = bus.sel && bus.offset >= offset_bits'(pwm_off)
                  && bus.offset < offset_bits'(pwm_off + pwm_size);
    assign wr   = hit && bus.write_en;
    assign word = bus.offset - offset_bits'(pwm_off);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            period <= '0;
            duty   <= '0;
            count  <= '0;
            wrap   <= 1'b0;
        end
        else
        begin
            if (wr && word == offset_bits'(0))
                period <= bus.wdata;
            if (wr && word == offset_bits'(1))
                duty <= bus.wdata;
            // >= also recovers when period drops below count
            wrap <= count >= period;
            if (count >= period)
                count <= '0;
            else
                count <= count + 1'b1;
        end
    end

    assign out = count < duty;

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (word)
                offset_bits'(0): rdata = period;
                offset_bits'(1): rdata = duty;
                default:         rdata = '0;
            endcase
        end
    end

endmodule

/* source/reflet_timer.sv */
/*
 * Interval timer:
 * run control, period register,
 * up-counter that wraps at period with a one-cycle interrupt.
 */
`timescale 1ns/1ps

module reflet_timer (
    input  logic                             clk,
    input  logic                             reset,
    reflet_bus_if.periph                     bus,
    output logic [reflet_pkg::word_size-1:0] rdata,
    output logic                             interrupt
);
    import reflet_pkg::*;

    logic                   hit;
    logic                   wr;
    logic [offset_bits-1:0] word;

    logic                 run;
    logic [word_size-1:0] period;
    logic [word_size-1:0] count;

    assign hit  = bus.sel && bus.offset >= offset_bits'(timer_off)
                  && bus.offset < offset_bits'(timer_off + timer_size);
    assign wr   = hit && bus.write_en;
    assign word = bus.offset - offset_bits'(timer_off);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run       <= 1'b0;
            period    <= '0;
            count     <= '0;
            interrupt <= 1'b0;
        end
        else
        begin
            interrupt <= 1'b0;
            if (wr && word == offset_bits'(1))
                period <= bus.wdata;

            // control write restarts from zero
            if (wr && word == offset_bits'(0))
            begin
                run   <= bus.wdata[0];
                count <= '0;
            end
            else if (run)
            begin
                if (count == period)
                begin
                    count     <= '0;
                    interrupt <= 1'b1;
                end
                else
                begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (word)
                offset_bits'(0): rdata = word_size'(run);
                offset_bits'(1): rdata = period;
                offset_bits'(2): rdata = count;
                default:         rdata = '0;
            endcase
        end
    end

endmodule

/* tb/reflet_clock_gen.sv */
/*
 * Testbench clock and reset source:
 * 8 ns clock, reset high for the first 10 cycles.
 */
`timescale 1ns/1ps

module reflet_clock_gen (
    output logic clk,
    output logic reset
);
    localparam int half_period  = 4;
    localparam int reset_cycles = 10;

    initial
    begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial
    begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* tb/reflet_peripheral_asserts.sv */
/*
 * Concurrent checks on the peripheral block:
 * read data with enable low, exti lines after reset,
 * timer interrupt pulse width. Bound to the top level.
 */
`timescale 1ns/1ps

module reflet_peripheral_asserts (
    input logic                             clk,
    input logic                             reset,
    input logic                             enable,
    input logic [reflet_pkg::word_size-1:0] data_out,
    input logic [reflet_pkg::irq_count-1:0] ext_int,
    input logic                             timer_int
);

    // no selection means nothing drives the read bus
    idle_read_zero: assert property (@(posedge clk) !enable |-> data_out == '0)
        else $error("data_out is nonzero while enable is low");

    reset_int_clear: assert property (@(posedge clk) reset |=> ext_int == '0)
        else $error("ext_int is set in the cycle after reset");

    // wrap pulse is a single cycle
    timer_pulse_single: assert property (@(posedge clk) disable iff (reset)
        timer_int |=> !timer_int)
        else $error("timer interrupt lasted two cycles");

endmodule

bind reflet_peripheral reflet_peripheral_asserts i_asserts (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .data_out  (data_out),
    .ext_int   (ext_int),
    .timer_int (timer_int)
);

/* tb/reflet_peripheral_tb.sv */
/*
 * Testbench for the peripheral block:
 * vector file reader, bus read and write tasks,
 * value checker, pwm high-time counter and watchdog.
 */
`timescale 1ns/1ps

module reflet_peripheral_tb;
    import reflet_pkg::*;

    localparam int cycles_per_line = 200;

    logic                 clk;
    logic                 reset;
    logic                 enable;
    logic [word_size-1:0] addr;
    logic [word_size-1:0] data_in;
    logic [word_size-1:0] data_out;
    logic                 write_en;
    logic [15:0]          gpi;
    logic [15:0]          gpo;
    logic                 pwm;
    logic [irq_count-1:0] ext_int;

    int line_count = 0;
    bit lines_counted = 1'b0;

    reflet_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    reflet_peripheral i_reflet_peripheral (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .write_en (write_en),
        .gpi      (gpi),
        .gpo      (gpo),
        .pwm      (pwm),
        .ext_int  (ext_int)
    );

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_problem(input string reason);
        $display("** Error at %0t ns: %s", $time, reason);
        stop_with_failure();
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected)
        begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic write_word(input logic [15:0] a, input logic [15:0] d);
        @(negedge clk);
        enable   = 1'b1;
        write_en = 1'b1;
        addr     = a;
        data_in  = d;
        @(negedge clk);
        enable   = 1'b0;
        write_en = 1'b0;
    endtask

    // second half checks that the same address reads zero with enable low
    task automatic read_word(input logic [15:0] a, input logic [15:0] expected);
        @(negedge clk);
        enable   = 1'b1;
        write_en = 1'b0;
        addr     = a;
        #2;
        check_value("data_out", data_out, expected);
        @(negedge clk);
        enable = 1'b0;
        #2;
        check_value("data_out with enable low", data_out, 16'h0000);
    endtask

    task automatic count_pwm_high(input int cycles, input int expected);
        int high;
        high = 0;
        repeat (cycles)
        begin
            @(negedge clk);
            if (pwm)
                high++;
        end
        check_value("pwm high cycles", 16'(high), 16'(expected));
    endtask

    // watchdog scaled by the length of the vector file
    initial
    begin
        wait (lines_counted);
        repeat ((line_count + 1) * cycles_per_line) @(posedge clk);
        report_problem("watchdog timeout, the vectors did not finish in time");
    end

    initial
    begin
        int               fd;
        int               status;
        int               num;
        int               expected_num;
        logic [8*16-1:0]  cmd;
        logic [8*128-1:0] line_buf;
        logic [15:0]      arg_a;
        logic [15:0]      arg_b;
        bit               done;

        enable   = 1'b0;
        write_en = 1'b0;
        addr     = '0;
        data_in  = '0;
        gpi      = '0;
        done     = 1'b0;

        fd = $fopen("tb/reflet_peripheral_vectors.txt", "r");
        if (fd == 0)
            report_problem("cannot open tb/reflet_peripheral_vectors.txt");
        while (!$feof(fd))
        begin
            status = $fgets(line_buf, fd);
            if (status > 0)
                line_count++;
        end
        $fclose(fd);
        lines_counted = 1'b1;

        fd = $fopen("tb/reflet_peripheral_vectors.txt", "r");
        wait (reset == 1'b0);

        while (!done)
        begin
            status = $fscanf(fd, "%s", cmd);
            if (status != 1)
                done = 1'b1;
            else if (cmd == "#")
                status = $fgets(line_buf, fd);
            else if (cmd == "write")
            begin
                status = $fscanf(fd, "%h %h", arg_a, arg_b);
                write_word(arg_a, arg_b);
            end
            else if (cmd == "read")
            begin
                status = $fscanf(fd, "%h %h", arg_a, arg_b);
                read_word(arg_a, arg_b);
            end
            else if (cmd == "pins")
            begin
                status = $fscanf(fd, "%h", arg_a);
                @(negedge clk);
                gpi = arg_a;
            end
            else if (cmd == "wait")
            begin
                status = $fscanf(fd, "%d", num);
                repeat (num) @(negedge clk);
            end
            else if (cmd == "expect_gpo")
            begin
                status = $fscanf(fd, "%h", arg_a);
                @(negedge clk);
                check_value("gpo", gpo, arg_a);
            end
            else if (cmd == "expect_int")
            begin
                status = $fscanf(fd, "%h", arg_a);
                @(negedge clk);
                check_value("ext_int", word_size'(ext_int), arg_a);
            end
            else if (cmd == "pwm_high")
            begin
                status = $fscanf(fd, "%d %d", num, expected_num);
                count_pwm_high(num, expected_num);
            end
            else
                report_problem($sformatf("unknown command '%0s' in the vector file", cmd));
        end
        $fclose(fd);

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* tb/reflet_peripheral_vectors.txt */
# columns: command then operands, hex for write addr data, read addr expected, pins gpi,
# expect_gpo value, expect_int value; decimal for wait n and pwm_high cycles expected
# hardware info words, then a read past the window
read FF00 0010
read FF01 4240
read FF02 000F
read FF03 001F
read FF0E 0000
# slow the pwm down and clear the wrap pulses seen since reset
write FF0C FFFF
write FF05 0007
read FF0C FFFF
read FF05 0000
# gpio output and synchronized input
write FF07 A5C3
expect_gpo A5C3
read FF07 A5C3
pins 1234
wait 2
read FF06 1234
# timer with period 5, pending bit 1 after the first wrap
write FF0A 0005
read FF0A 0005
write FF09 0001
wait 6
read FF05 0002
read FF0B 0003
write FF09 0000
# exti mask and write-one-to-clear
expect_int 0
write FF04 0007
expect_int 2
write FF05 0002
expect_int 0
read FF05 0000
# gpio rising edge, only bit 0 is masked in
write FF08 0001
pins 1236
wait 4
read FF05 0000
pins 1237
wait 4
read FF05 0001
expect_int 1
write FF05 0001
read FF05 0000
# pwm duty 3 of 10 clocks, then duty above the period
write FF0C 0009
write FF0D 0003
pwm_high 100 30
write FF0D 000F
read FF0D 000F
pwm_high 100 100
expect_int 4
